/* design/pbuf_pkg.sv */
package pbuf_pkg;

    // data word width
    parameter int word_w = 16;

    // page index, 2048 pages per slice
    parameter int page_w = 11;

    // word position inside a page
    parameter int batch_w = 3;

    // data sram address = page index plus batch
    parameter int sram_addr_w = 14;

    // slice number prepended to page addresses
    parameter int slice_w = 5;

    // column parity check code
    parameter int code_w = 8;

    // header length field
    parameter int len_w = 6;

    parameter int num_pages = 2048;

    // first word of a packet, msb first
    typedef struct packed {
        logic [len_w-1:0] len_m1;
        logic [2:0]       resv;
        logic [2:0]       prior;
        logic [3:0]       dest;
    } pkt_header_s;

    // one incoming word, seen as payload or as header
    typedef union packed {
        logic [word_w-1:0] raw;
        pkt_header_s       hdr;
    } pkt_word_u;

endpackage

/* design/free_page_if.sv */
interface free_page_if;

    // allocation side
    logic [pbuf_pkg::len_w-1:0]  alloc_offset;
    logic                        alloc_peek;
    logic                        alloc_take;
    // registered page at the read address
    logic [pbuf_pkg::page_w-1:0] free_page;

    // pages handed back after read out
    logic [pbuf_pkg::page_w-1:0] release_page;
    logic                        release_en;

    modport ctrl (
        output alloc_offset, alloc_peek, alloc_take,
        output release_page, release_en,
        input  free_page
    );

    modport list (
        input  alloc_offset, alloc_peek, alloc_take,
        input  release_page, release_en,
        output free_page
    );

endinterface

/* design/page_sram.sv */
module page_sram (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_en,
    input  logic [pbuf_pkg::sram_addr_w-1:0] wr_addr,
    input  logic [pbuf_pkg::word_w-1:0]      din,
    input  logic                             rd_en,
    input  logic [pbuf_pkg::sram_addr_w-1:0] rd_addr,
    output logic [pbuf_pkg::word_w-1:0]      dout
);

    // 16k words, one write and one read port
    logic [pbuf_pkg::word_w-1:0] mem [2**pbuf_pkg::sram_addr_w];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= din;
        end
    end

    // output register, holds while rd_en is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (rd_en) begin
            dout <= mem[rd_addr];
        end
    end

endmodule

/* design/ecc_encoder.sv */
module ecc_encoder (
    input  logic [pbuf_pkg::word_w-1:0] data_0,
    input  logic [pbuf_pkg::word_w-1:0] data_1,
    input  logic [pbuf_pkg::word_w-1:0] data_2,
    input  logic [pbuf_pkg::word_w-1:0] data_3,
    input  logic [pbuf_pkg::word_w-1:0] data_4,
    input  logic [pbuf_pkg::word_w-1:0] data_5,
    input  logic [pbuf_pkg::word_w-1:0] data_6,
    input  logic [pbuf_pkg::word_w-1:0] data_7,
    output logic [pbuf_pkg::code_w-1:0] code
);

    // xor of all eight words, bit by bit
    logic [pbuf_pkg::word_w-1:0] word_fold;

    // first halve the page into one word
    assign word_fold = data_0 ^ data_1 ^ data_2 ^ data_3
                     ^ data_4 ^ data_5 ^ data_6 ^ data_7;

    // then fold high byte onto low byte
    // bit i covers bit i and bit i+8 of every word
    // so the code is the column parity of all 16 bytes
    assign code = word_fold[pbuf_pkg::code_w-1:0]
                ^ word_fold[pbuf_pkg::word_w-1:pbuf_pkg::code_w];

endmodule

/* design/free_page_list.sv */
module free_page_list (
    input  logic       clk,
    input  logic       rst_n,
    free_page_if.list  fp
);

    // circular list of free page numbers
    logic [pbuf_pkg::page_w-1:0] page_ram [pbuf_pkg::num_pages];

    logic [pbuf_pkg::page_w-1:0] head_ptr;
    logic [pbuf_pkg::page_w-1:0] tail_ptr;
    logic [pbuf_pkg::page_w-1:0] rd_ptr;
    // one extra bit to count up to num_pages
    logic [pbuf_pkg::page_w:0]   fill_cnt;
    logic                        filling;
    logic                        push;
    logic [pbuf_pkg::page_w-1:0] push_page;

    assign filling = fill_cnt != pbuf_pkg::num_pages;

    // release wins over the self fill
    assign push      = fp.release_en || filling;
    assign push_page = fp.release_en ? fp.release_page : fill_cnt[pbuf_pkg::page_w-1:0];

    // peek ahead for the tail page of a new packet
    assign rd_ptr = fp.alloc_peek ? head_ptr + fp.alloc_offset : head_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            fill_cnt <= '0;
        end else begin
            if (fp.alloc_take) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            // fill stalls for a cycle when a release comes in
            if (filling && !fp.release_en) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            page_ram[tail_ptr] <= push_page;
        end
        fp.free_page <= page_ram[rd_ptr];
    end

endmodule

/* design/sram_interface.sv */
module sram_interface #(
    parameter logic [pbuf_pkg::slice_w-1:0] slice_idx = '0,
    localparam int addr_w = pbuf_pkg::slice_w + pbuf_pkg::page_w
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [4:0]                    time_stamp,
    input  logic                          wr_xfer_data_vld,
    input  logic [pbuf_pkg::word_w-1:0]   wr_xfer_data,
    input  logic                          wr_end_of_packet,
    output logic [3:0]                    wr_packet_dest_port,
    output logic [2:0]                    wr_packet_prior,
    output logic [addr_w-1:0]             wr_packet_head_addr,
    output logic [addr_w-1:0]             wr_packet_tail_addr,
    output logic                          wr_packet_join_request,
    output logic [5:0]                    wr_packet_join_time_stamp,
    input  logic                          concatenate_enable,
    input  logic [pbuf_pkg::page_w-1:0]   concatenate_head,
    input  logic [addr_w-1:0]             concatenate_tail,
    input  logic                          rd_page_down,
    input  logic [pbuf_pkg::page_w-1:0]   rd_page,
    output logic                          rd_xfer_data_vld,
    output logic [pbuf_pkg::word_w-1:0]   rd_xfer_data,
    output logic [addr_w-1:0]             rd_next_page,
    output logic [pbuf_pkg::code_w-1:0]   rd_ecc_code,
    output logic [pbuf_pkg::page_w-1:0]   free_space
);

    // write fsm states
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_first = 2'd1;
    localparam logic [1:0] st_later = 2'd2;
    // read batch 8 means no page in flight
    localparam logic [pbuf_pkg::batch_w:0] rd_idle  = 8;
    localparam logic [pbuf_pkg::batch_w:0] rd_first = 1;

    free_page_if fp ();

    pbuf_pkg::pkt_word_u               in_word;
    logic [1:0]                        wr_state;
    logic [pbuf_pkg::page_w-1:0]       wr_page;
    logic [pbuf_pkg::batch_w-1:0]      wr_batch;
    logic [1:0]                        regain_tick;
    logic                              hdr_start;
    logic                              page_full;
    logic                              wr_last;
    logic [pbuf_pkg::len_w:0]          pkt_len;
    logic [4:0]                        ts_next;
    logic [pbuf_pkg::word_w-1:0]       ecc_buf [8];
    logic                              ecc_we;
    logic [pbuf_pkg::page_w-1:0]       ecc_wr_page;
    logic [pbuf_pkg::code_w-1:0]       ecc_din;
    logic [pbuf_pkg::code_w-1:0]       ecc_ram [pbuf_pkg::num_pages];
    logic [addr_w-1:0]                 jump_table [pbuf_pkg::num_pages];
    logic [pbuf_pkg::batch_w:0]        rd_batch;
    logic [pbuf_pkg::page_w-1:0]       rd_page_q;
    logic                              rd_en;
    logic [pbuf_pkg::sram_addr_w-1:0]  rd_addr;

    // same word read as payload and as header
    assign in_word.raw = wr_xfer_data;
    assign hdr_start   = wr_xfer_data_vld && wr_state == st_idle;
    assign page_full   = wr_xfer_data_vld && wr_batch == '1;
    assign wr_last     = wr_xfer_data_vld && wr_end_of_packet;
    assign ts_next     = time_stamp + 5'd1;

    // header peeks head + len_m1 to find the tail page
    assign fp.alloc_offset = in_word.hdr.len_m1;
    assign fp.alloc_peek   = hdr_start;
    // page is consumed on its first word
    assign fp.alloc_take   = wr_xfer_data_vld && wr_batch == '0;
    // read pages go straight back to the list
    assign fp.release_page = rd_page;
    assign fp.release_en   = rd_page_down;

    free_page_list u_free_list (
        .clk   (clk),
        .rst_n (rst_n),
        .fp    (fp.list)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= st_idle;
        end else if (wr_last) begin
            wr_state <= st_idle;
        end else if (hdr_start) begin
            wr_state <= st_first;
        end else if (wr_state == st_first && page_full) begin
            wr_state <= st_later;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_batch    <= '0;
            regain_tick <= '0;
            wr_page     <= '0;
        end else begin
            if (wr_last) begin
                wr_batch <= '0;
            end else if (wr_xfer_data_vld) begin
                wr_batch <= wr_batch + 1'b1;
            end
            // reload once the list output has settled after eop
            if (wr_last) begin
                regain_tick <= 2'd3;
            end else if (regain_tick != '0) begin
                regain_tick <= regain_tick - 1'b1;
            end
            if (page_full || regain_tick == 2'd1) begin
                wr_page <= fp.free_page;
            end
        end
    end

    // header fields, tail comes out of the peek a cycle later
    always_ff @(posedge clk) begin
        if (hdr_start) begin
            wr_packet_dest_port <= in_word.hdr.dest;
            wr_packet_prior     <= in_word.hdr.prior;
            wr_packet_head_addr <= {slice_idx, wr_page};
            pkt_len             <= in_word.hdr.len_m1 + 1'b1;
        end
        if (wr_packet_join_request) begin
            wr_packet_tail_addr <= {slice_idx, fp.free_page};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_packet_join_request    <= 1'b0;
            wr_packet_join_time_stamp <= 6'd32;
        end else begin
            wr_packet_join_request <= hdr_start;
            if (hdr_start) begin
                wr_packet_join_time_stamp <= {1'b0, ts_next};
            end else if ({1'b0, ts_next} == wr_packet_join_time_stamp) begin
                // stamp expired, 32 marks none pending
                wr_packet_join_time_stamp <= 6'd32;
            end
        end
    end

    // link current page to next free page, external writes win
    always_ff @(posedge clk) begin
        if (concatenate_enable) begin
            jump_table[concatenate_head] <= concatenate_tail;
        end else if (wr_xfer_data_vld &&
                     wr_page != wr_packet_tail_addr[pbuf_pkg::page_w-1:0]) begin
            jump_table[wr_page] <= {slice_idx, fp.free_page};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_page_down) begin
            rd_next_page <= jump_table[rd_page];
        end
    end

    // page words for the code, cleared at each new page
    always_ff @(posedge clk) begin
        if (wr_xfer_data_vld) begin
            for (int i = 1; i < 8; i++) begin
                if (wr_batch == '0) begin
                    ecc_buf[i] <= '0;
                end
            end
            ecc_buf[wr_batch] <= in_word.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ecc_we <= 1'b0;
        end else begin
            ecc_we <= page_full || wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (page_full || wr_last) begin
            ecc_wr_page <= wr_page;
        end
    end

    ecc_encoder u_ecc (
        .data_0 (ecc_buf[0]),
        .data_1 (ecc_buf[1]),
        .data_2 (ecc_buf[2]),
        .data_3 (ecc_buf[3]),
        .data_4 (ecc_buf[4]),
        .data_5 (ecc_buf[5]),
        .data_6 (ecc_buf[6]),
        .data_7 (ecc_buf[7]),
        .code   (ecc_din)
    );

    // buffer is complete the cycle after the last word
    always_ff @(posedge clk) begin
        if (ecc_we) begin
            ecc_ram[ecc_wr_page] <= ecc_din;
        end
        if (rd_page_down) begin
            rd_ecc_code <= ecc_ram[rd_page];
        end
    end

    // read side, word 0 addressed directly from the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_batch         <= rd_idle;
            rd_xfer_data_vld <= 1'b0;
        end else begin
            if (rd_page_down) begin
                rd_batch <= rd_first;
            end else if (rd_batch != rd_idle) begin
                rd_batch <= rd_batch + 1'b1;
            end
            rd_xfer_data_vld <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_page_down) begin
            rd_page_q <= rd_page;
        end
    end

    assign rd_en   = rd_page_down || rd_batch != rd_idle;
    assign rd_addr = rd_page_down ? {rd_page, {pbuf_pkg::batch_w{1'b0}}}
                                  : {rd_page_q, rd_batch[pbuf_pkg::batch_w-1:0]};

    // packet reserves its pages at join, each read gives one back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_space <= 11'd2047;
        end else if (wr_packet_join_request && rd_page_down) begin
            free_space <= free_space - pkt_len + 1'b1;
        end else if (wr_packet_join_request) begin
            free_space <= free_space - pkt_len;
        end else if (rd_page_down) begin
            free_space <= free_space + 1'b1;
        end
    end

    page_sram u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_xfer_data_vld),
        .wr_addr ({wr_page, wr_batch}),
        .din     (in_word.raw),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .dout    (rd_xfer_data)
    );

endmodule

/* design/packet_buffer_top.sv */
module packet_buffer_top #(
    parameter logic [pbuf_pkg::slice_w-1:0] slice_idx = '0
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [4:0]   time_stamp,
    input  logic         wr_xfer_data_vld,
    input  logic [15:0]  wr_xfer_data,
    input  logic         wr_end_of_packet,
    output logic [3:0]   wr_packet_dest_port,
    output logic [2:0]   wr_packet_prior,
    output logic [15:0]  wr_packet_head_addr,
    output logic [15:0]  wr_packet_tail_addr,
    output logic         wr_packet_join_request,
    output logic [5:0]   wr_packet_join_time_stamp,
    input  logic         concatenate_enable,
    input  logic [10:0]  concatenate_head,
    input  logic [15:0]  concatenate_tail,
    input  logic         rd_page_down,
    input  logic [10:0]  rd_page,
    output logic         rd_xfer_data_vld,
    output logic [15:0]  rd_xfer_data,
    output logic [15:0]  rd_next_page,
    output logic [7:0]   rd_ecc_code,
    output logic [10:0]  free_space
);

    // one slice, its number fixed here
    sram_interface #(
        .slice_idx (slice_idx)
    ) u_slice (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .time_stamp                (time_stamp),
        .wr_xfer_data_vld          (wr_xfer_data_vld),
        .wr_xfer_data              (wr_xfer_data),
        .wr_end_of_packet          (wr_end_of_packet),
        .wr_packet_dest_port       (wr_packet_dest_port),
        .wr_packet_prior           (wr_packet_prior),
        .wr_packet_head_addr       (wr_packet_head_addr),
        .wr_packet_tail_addr       (wr_packet_tail_addr),
        .wr_packet_join_request    (wr_packet_join_request),
        .wr_packet_join_time_stamp (wr_packet_join_time_stamp),
        .concatenate_enable        (concatenate_enable),
        .concatenate_head          (concatenate_head),
        .concatenate_tail          (concatenate_tail),
        .rd_page_down              (rd_page_down),
        .rd_page                   (rd_page),
        .rd_xfer_data_vld          (rd_xfer_data_vld),
        .rd_xfer_data              (rd_xfer_data),
        .rd_next_page              (rd_next_page),
        .rd_ecc_code               (rd_ecc_code),
        .free_space                (free_space)
    );

endmodule

/* test/tb_packet_buffer.sv */
module tb_packet_buffer;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic [4:0]  time_stamp;
    logic        wr_xfer_data_vld;
    logic [15:0] wr_xfer_data;
    logic        wr_end_of_packet;
    logic [3:0]  wr_packet_dest_port;
    logic [2:0]  wr_packet_prior;
    logic [15:0] wr_packet_head_addr;
    logic [15:0] wr_packet_tail_addr;
    logic        wr_packet_join_request;
    logic [5:0]  wr_packet_join_time_stamp;
    logic        concatenate_enable;
    logic [10:0] concatenate_head;
    logic [15:0] concatenate_tail;
    logic        rd_page_down;
    logic [10:0] rd_page;
    logic        rd_xfer_data_vld;
    logic [15:0] rd_xfer_data;
    logic [15:0] rd_next_page;
    logic [7:0]  rd_ecc_code;
    logic [10:0] free_space;

    // packets from the stimulus file
    int          num_pkts;
    int          pk_n [16];
    logic [3:0]  pk_dest [16];
    logic [2:0]  pk_prior [16];
    logic [4:0]  pk_ts [16];
    logic [15:0] pk_seed [16];
    logic [7:0]  pk_code [16][3];
    // learned from the join pulse
    logic [10:0] pk_head [16];
    logic [10:0] pk_tail [16];

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [10:0] fs_model;

    packet_buffer_top #(
        .slice_idx (5'd5)
    ) dut0 (.*);

    always #2 clk = ~clk;

    function automatic int page_count(input int idx);
        return (pk_n[idx] + 7) / 8;
    endfunction

    // word 0 is the header and the payload is seed plus word index
    function automatic logic [15:0] expect_word(input int idx, input int w);
        pbuf_pkg::pkt_word_u u;
        u.hdr.len_m1 = 6'(page_count(idx) - 1);
        u.hdr.resv   = '0;
        u.hdr.prior  = pk_prior[idx];
        u.hdr.dest   = pk_dest[idx];
        if (w == 0) begin
            return u.raw;
        end
        return pk_seed[idx] + 16'(w);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_event(input string what, input bit ok);
        assert (ok) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    got;
        string line;
        int    n_v, d_v, p_v, t_v, s_v, c0, c1, c2;
        fd = $fopen("test/packet_buffer_stimulus.txt", "r");
        check_event("stimulus file could not be opened", fd != 0);
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#" && num_pkts < 16) begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                  n_v, d_v, p_v, t_v, s_v, c0, c1, c2);
                    if (got == 8) begin
                        pk_n[num_pkts]       = n_v;
                        pk_dest[num_pkts]    = 4'(d_v);
                        pk_prior[num_pkts]   = 3'(p_v);
                        pk_ts[num_pkts]      = 5'(t_v);
                        pk_seed[num_pkts]    = 16'(s_v);
                        pk_code[num_pkts][0] = 8'(c0);
                        pk_code[num_pkts][1] = 8'(c1);
                        pk_code[num_pkts][2] = 8'(c2);
                        num_pkts++;
                    end
                end
            end
            $fclose(fd);
        end
        check_event("stimulus file holds no packets", num_pkts > 0);
    endtask

    // drives one packet and watches for its join pulse
    task automatic write_packet(input int idx);
        int          c;
        int          join_cyc;
        int          pulses;
        int          errs_before;
        logic [10:0] fs_after;
        string       name;
        errs_before = errors;
        name = $sformatf("write p%0d", idx);
        c = 0;
        join_cyc = -1;
        pulses = 0;
        fs_after = 'x;
        while (!(join_cyc >= 0 && c > pk_n[idx] + 2 && c > join_cyc + 2) && c < 64) begin
            @(posedge clk);
            if (c < pk_n[idx]) begin
                wr_xfer_data_vld <= 1'b1;
                wr_xfer_data     <= expect_word(idx, c);
                wr_end_of_packet <= (c == pk_n[idx] - 1);
                time_stamp       <= pk_ts[idx];
            end else begin
                wr_xfer_data_vld <= 1'b0;
                wr_end_of_packet <= 1'b0;
            end
            @(negedge clk);
            if (wr_packet_join_request) begin
                pulses++;
                if (join_cyc < 0) begin
                    join_cyc = c;
                    check_value({name, " dest"}, pk_dest[idx], wr_packet_dest_port);
                    check_value({name, " prior"}, pk_prior[idx], wr_packet_prior);
                    check_value({name, " head slice"}, 5, wr_packet_head_addr[15:11]);
                    check_value({name, " stamp"}, {1'b0, 5'(pk_ts[idx] + 5'd1)},
                                wr_packet_join_time_stamp);
                    pk_head[idx] = wr_packet_head_addr[10:0];
                end
            end
            if (join_cyc >= 0 && c == join_cyc + 1) begin
                fs_after = free_space;
                check_value({name, " tail slice"}, 5, wr_packet_tail_addr[15:11]);
                pk_tail[idx] = wr_packet_tail_addr[10:0];
            end
            c++;
        end
        check_event($sformatf("%s saw no join request within 64 cycles", name),
                    join_cyc >= 0);
        if (join_cyc >= 0) begin
            check_value({name, " join cycle"}, 1, join_cyc);
            check_value({name, " join pulses"}, 1, pulses);
            fs_model = fs_model - 11'(page_count(idx));
            check_value({name, " free space"}, fs_model, fs_after);
        end
        finish_test(name, errs_before);
    endtask

    // walks the page chain from head to tail
    task automatic read_packet(input int idx);
        int          pg;
        int          t;
        int          cnt;
        int          w;
        int          errs_before;
        logic [10:0] page;
        string       name;
        errs_before = errors;
        name = $sformatf("read p%0d", idx);
        page = pk_head[idx];
        for (pg = 0; pg < page_count(idx); pg++) begin
            @(posedge clk);
            rd_page_down <= 1'b1;
            rd_page      <= page;
            @(posedge clk);
            rd_page_down <= 1'b0;
            @(negedge clk);
            t = 0;
            while (!rd_xfer_data_vld && t < 64) begin
                @(negedge clk);
                t++;
            end
            if (!rd_xfer_data_vld) begin
                check_event($sformatf("%s page %0d gave no valid data", name, pg), 0);
                break;
            end
            fs_model = fs_model + 11'd1;
            check_value($sformatf("%s page %0d free space", name, pg), fs_model, free_space);
            check_value($sformatf("%s page %0d code", name, pg), pk_code[idx][pg], rd_ecc_code);
            if (pg == page_count(idx) - 1) begin
                check_value({name, " tail page"}, pk_tail[idx], page);
            end else begin
                check_value({name, " next slice"}, 5, rd_next_page[15:11]);
            end
            cnt = 0;
            while (rd_xfer_data_vld && cnt < 64) begin
                w = pg * 8 + cnt;
                if (w < pk_n[idx]) begin
                    check_value($sformatf("%s word %0d", name, w), expect_word(idx, w),
                                rd_xfer_data);
                end
                cnt++;
                @(negedge clk);
            end
            check_value($sformatf("%s page %0d valid cycles", name, pg), 8, cnt);
            page = rd_next_page[10:0];
        end
        finish_test(name, errs_before);
    endtask

    initial begin
        int errs_before;
        clk = 1'b0;
        rst_n = 1'b0;
        time_stamp = '0;
        wr_xfer_data_vld = 1'b0;
        wr_xfer_data = '0;
        wr_end_of_packet = 1'b0;
        concatenate_enable = 1'b0;
        concatenate_head = '0;
        concatenate_tail = '0;
        rd_page_down = 1'b0;
        rd_page = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        num_pkts = 0;
        void'($urandom(32'h9a97));
        read_stimulus();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errs_before = errors;
        check_value("reset free space", 2047, free_space);
        check_value("reset join", 0, wr_packet_join_request);
        check_value("reset read valid", 0, rd_xfer_data_vld);
        check_value("reset stamp", 32, wr_packet_join_time_stamp);
        finish_test("reset", errs_before);
        fs_model = 11'd2047;

        // free list fills one page per cycle
        repeat (2100) @(negedge clk);

        for (int i = 0; i < num_pkts; i++) begin
            write_packet(i);
            repeat ($urandom_range(7, 0)) @(negedge clk);
        end
        for (int i = 0; i < num_pkts; i++) begin
            read_packet(i);
        end

        errs_before = errors;
        check_value("final free space", 2047, free_space);
        finish_test("final free space", errs_before);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* test/packet_buffer_stimulus.txt */
# one packet per line, all fields hex
# words dest prior stamp seed code0 code1 code2
5 3 2 4 1200 27 00 00
8 9 5 1f 3400 6d 00 00
b 1 7 a 0500 70 0e 00
14 f 0 14 2013 3c 38 04
2 6 3 0 abcd 53 00 00
9 2 1 11 0100 17 09 00

/* sim.f */
design/pbuf_pkg.sv
design/free_page_if.sv
design/page_sram.sv
design/ecc_encoder.sv
design/free_page_list.sv
design/sram_interface.sv
design/packet_buffer_top.sv
test/tb_packet_buffer.sv

/* Bender.yml */
package:
  name: packet_buffer

sources:
  - design/pbuf_pkg.sv
  - design/free_page_if.sv
  - design/page_sram.sv
  - design/ecc_encoder.sv
  - design/free_page_list.sv
  - design/sram_interface.sv
  - design/packet_buffer_top.sv
  - target: test
    files:
      - test/tb_packet_buffer.sv
